/* Bender.yml */
package:
  name: arm_core

sources:
  - armPkg.sv
  - armAlu.sv
  - armRegFile.sv
  - armDecoder.sv
  - armCondUnit.sv
  - armDatapath.sv
  - armCore.sv
  - target: test
    files:
      - armCore_assert.sv
      - armCoreChecker.sv
      - armCoreTb.sv

/* armAlu.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 32-bit ALU, shared adder for ADD and SUB plus bitwise logic
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module armAlu import armPkg::*; (
   input  word_t    a,
   input  word_t    b,
   input  aluCtrl_t aluCtrl,
   output word_t    result,
   output flags_t   aluFlags
);

   logic        isSub;
   logic        isArith;
   word_t       bIn;
   logic [32:0] sum;

   assign isSub   = (aluCtrl == ALU_SUB);
   assign isArith = (aluCtrl == ALU_ADD) || isSub;
   assign bIn     = isSub ? ~b : b;
   assign sum     = {1'b0, a} + {1'b0, bIn} + {32'd0, isSub};   // Two's complement subtract

   always_comb begin
      case (aluCtrl)
         ALU_AND: result = a & b;
         ALU_ORR: result = a | b;
         ALU_EOR: result = a ^ b;
         default: result = sum[31:0];
      endcase
   end

   assign aluFlags[3] = result[31];
   assign aluFlags[2] = (result == '0);
   assign aluFlags[1] = isArith & sum[32];   // Carry out, not-borrow on SUB
   // Overflow when effective operand signs agree and the sum sign differs
   assign aluFlags[0] = isArith & ~(a[31] ^ b[31] ^ isSub) & (a[31] ^ sum[31]);

endmodule

/* armCondUnit.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// NZCV flag registers and condition check that gate every write
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module armCondUnit import armPkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  word_t      instr,
   input  logic       instrReady,
   input  logic       regW,
   input  logic       memW,
   input  logic       branch,
   input  logic       noWrite,
   input  logic [1:0] flagW,
   input  flags_t     aluFlags,
   output logic       regWrite,
   output logic       memWrite,
   output logic       memStrobe,
   output logic       pcSrc
);

   flags_t     flags;
   cond_t      cond;
   logic       condEx;
   logic       execute;
   logic [1:0] flagWrite;
   logic       neg, zero, carry, overflow;

   assign cond = instr[31:28];
   assign {neg, zero, carry, overflow} = flags;

   always_comb begin
      case (cond)
         COND_EQ: condEx = zero;
         COND_NE: condEx = ~zero;
         COND_CS: condEx = carry;
         COND_CC: condEx = ~carry;
         COND_MI: condEx = neg;
         COND_PL: condEx = ~neg;
         COND_VS: condEx = overflow;
         COND_VC: condEx = ~overflow;
         COND_HI: condEx = carry & ~zero;
         COND_LS: condEx = ~carry | zero;
         COND_GE: condEx = (neg == overflow);
         COND_LT: condEx = (neg != overflow);
         COND_GT: condEx = ~zero & (neg == overflow);
         COND_LE: condEx = zero | (neg != overflow);
         COND_AL: condEx = 1'b1;
         default: condEx = 1'b0;   // 1111 never executes here
      endcase
   end

   // Nothing retires unless the instruction word is valid
   assign execute   = condEx & instrReady;
   assign flagWrite = flagW & {2{execute}};
   assign regWrite  = regW & ~noWrite & execute;
   assign memStrobe = (instr[27:26] == OP_MEM) & execute;
   assign memWrite  = memStrobe & memW;
   assign pcSrc     = branch & execute;

   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         flags <= '0;
      end else begin
         if (flagWrite[1]) flags[3:2] <= aluFlags[3:2];   // N Z
         if (flagWrite[0]) flags[1:0] <= aluFlags[1:0];   // C V
      end
   end

endmodule

/* armCore.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-cycle ARMv4 subset core, memories attach through the ports
// instr must be valid with instrReady in the cycle pc is presented
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module armCore import armPkg::*; (
   input  logic  clk,
   input  logic  reset,
   input  word_t instr,
   input  logic  instrReady,
   input  word_t readData,
   output word_t pc,
   output word_t aluResult,
   output word_t writeData,
   output logic  memWrite,
   output logic  memStrobe
);

   logic       regW, memW, branch, noWrite;
   logic [1:0] flagW;
   logic [1:0] regSrc;
   immSrc_t    immSrc;
   logic       aluSrc, memToReg;
   aluCtrl_t   aluCtrl;
   logic       regWrite, pcSrc;
   flags_t     aluFlags;

   armDecoder u_decoder (
      .instr    (instr),
      .regW     (regW),
      .memW     (memW),
      .branch   (branch),
      .noWrite  (noWrite),
      .flagW    (flagW),
      .regSrc   (regSrc),
      .immSrc   (immSrc),
      .aluSrc   (aluSrc),
      .memToReg (memToReg),
      .aluCtrl  (aluCtrl)
   );

   armCondUnit u_condUnit (
      .clk        (clk),
      .reset      (reset),
      .instr      (instr),
      .instrReady (instrReady),
      .regW       (regW),
      .memW       (memW),
      .branch     (branch),
      .noWrite    (noWrite),
      .flagW      (flagW),
      .aluFlags   (aluFlags),
      .regWrite   (regWrite),
      .memWrite   (memWrite),
      .memStrobe  (memStrobe),
      .pcSrc      (pcSrc)
   );

   armDatapath u_datapath (
      .clk        (clk),
      .reset      (reset),
      .instr      (instr),
      .readData   (readData),
      .instrReady (instrReady),
      .regWrite   (regWrite),
      .pcSrc      (pcSrc),
      .regSrc     (regSrc),
      .immSrc     (immSrc),
      .aluSrc     (aluSrc),
      .memToReg   (memToReg),
      .aluCtrl    (aluCtrl),
      .pc         (pc),
      .aluResult  (aluResult),
      .writeData  (writeData),
      .aluFlags   (aluFlags)
   );

endmodule

/* armCoreChecker.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Compares armCore outputs with the expected trace fields each cycle
// Prints one line per finished test and the closing counts on request
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module armCoreChecker import armPkg::*; (
   input  logic       clk,
   input  logic       checkEn,
   input  int         testNum,
   input  word_t      expPc,
   input  logic       expStrobe,
   input  logic       expWrite,
   input  word_t      expAluResult,
   input  word_t      expWriteData,
   input  logic [1:0] mask,        // Bit 0 aluResult, bit 1 writeData
   input  word_t      pc,
   input  logic       memStrobe,
   input  logic       memWrite,
   input  word_t      aluResult,
   input  word_t      writeData,
   output int         errorCount
);

   int curTest;
   int testErrors;
   int testLines;
   int testsRun;
   int testsFailed;

   initial begin
      curTest     = 0;
      testErrors  = 0;
      testLines   = 0;
      testsRun    = 0;
      testsFailed = 0;
      errorCount  = 0;
   end

   task automatic compareValue(input string name, input word_t expected, input word_t actual);
      if (actual !== expected) begin
         $display("[ERROR] test %0d pc %08h: %s expected %08h, got %08h",
                  testNum, expPc, name, expected, actual);
         testErrors++;
         errorCount++;
      end
   endtask

   task automatic closeTest();
      testsRun++;
      if (testErrors == 0) begin
         $display("Test %0d passed, %0d cycles", curTest, testLines);
      end else begin
         testsFailed++;
         $display("Test %0d failed, %0d mismatches", curTest, testErrors);
      end
   endtask

   task automatic finishReport();
      if (curTest != 0)
         closeTest();
      curTest = 0;
      $display("Tests run %0d, passed %0d, failed %0d, mismatches %0d",
               testsRun, testsRun - testsFailed, testsFailed, errorCount);
   endtask

   // Outputs settle after the falling-edge drive and pc moves only after this edge
   always @(posedge clk) begin
      if (checkEn) begin
         if (testNum != curTest) begin
            if (curTest != 0)
               closeTest();
            curTest    = testNum;
            testErrors = 0;
            testLines  = 0;
         end
         testLines++;
         compareValue("pc", expPc, pc);
         compareValue("memStrobe", {31'd0, expStrobe}, {31'd0, memStrobe});
         compareValue("memWrite", {31'd0, expWrite}, {31'd0, memWrite});
         if (mask[0])
            compareValue("aluResult", expAluResult, aluResult);
         if (mask[1])
            compareValue("writeData", expWriteData, writeData);
      end
   end

endmodule

/* armCoreTb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench top that replays armTrace.txt into armCore one line per cycle
// Clock, reset, stimulus and watchdog live here while the checker compares
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module armCoreTb import armPkg::*; ();

   localparam int CLK_PERIOD     = 100;   // ns
   localparam int RESET_CYCLES   = 8;
   localparam int WATCHDOG_SLACK = 20;    // Cycles on top of the trace length
   localparam int TRACE_FIELDS   = 10;

   logic       clk;
   logic       reset;
   word_t      instr;
   logic       instrReady;
   word_t      readData;
   word_t      pc, aluResult, writeData;
   logic       memWrite, memStrobe;

   // Trace contents with one entry per line
   int         lineTest [$];
   word_t      lineReady [$], lineInstr [$], lineReadData [$], lineExpPc [$];
   word_t      lineStrobe [$], lineWrite [$], lineAlu [$], lineWdata [$], lineMask [$];
   bit         traceLoaded;
   bit         loadOk;

   logic       checkEn;
   int         testNum;
   word_t      expPc, expAluResult, expWriteData;
   logic       expStrobe, expWrite;
   logic [1:0] mask;
   int         errorCount;

   armCore u_armCore (
      .clk        (clk),
      .reset      (reset),
      .instr      (instr),
      .instrReady (instrReady),
      .readData   (readData),
      .pc         (pc),
      .aluResult  (aluResult),
      .writeData  (writeData),
      .memWrite   (memWrite),
      .memStrobe  (memStrobe)
   );

   armCoreChecker u_checker (
      .clk          (clk),
      .checkEn      (checkEn),
      .testNum      (testNum),
      .expPc        (expPc),
      .expStrobe    (expStrobe),
      .expWrite     (expWrite),
      .expAluResult (expAluResult),
      .expWriteData (expWriteData),
      .mask         (mask),
      .pc           (pc),
      .memStrobe    (memStrobe),
      .memWrite     (memWrite),
      .aluResult    (aluResult),
      .writeData    (writeData),
      .errorCount   (errorCount)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic loadTrace(output bit ok);
      int    fd;
      int    fields;
      int    testId;
      bit    bad;
      string line;
      word_t rdy, ins, rdat, epc, stb, wr, ealu, ewd, msk;
      bad = 1'b0;
      fd  = $fopen("armTrace.txt", "r");
      if (fd == 0) begin
         $display("Could not open armTrace.txt for reading");
         bad = 1'b1;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#")
               continue;
            fields = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h",
                             testId, rdy, ins, rdat, epc, stb, wr, ealu, ewd, msk);
            if (fields != TRACE_FIELDS) begin
               $display("Malformed trace line: %s", line);
               bad = 1'b1;
            end else begin
               lineTest.push_back(testId);
               lineReady.push_back(rdy);
               lineInstr.push_back(ins);
               lineReadData.push_back(rdat);
               lineExpPc.push_back(epc);
               lineStrobe.push_back(stb);
               lineWrite.push_back(wr);
               lineAlu.push_back(ealu);
               lineWdata.push_back(ewd);
               lineMask.push_back(msk);
            end
         end
         $fclose(fd);
         if (lineTest.size() == 0) begin
            $display("The trace holds no stimulus lines");
            bad = 1'b1;
         end
      end
      ok = !bad;
   endtask

   task automatic driveLine(input int idx);
      instrReady   = lineReady[idx][0];
      instr        = lineReady[idx][0] ? lineInstr[idx] : $urandom();   // Don't care while stalled
      readData     = lineReadData[idx];
      testNum      = lineTest[idx];
      expPc        = lineExpPc[idx];
      expStrobe    = lineStrobe[idx][0];
      expWrite     = lineWrite[idx][0];
      expAluResult = lineAlu[idx];
      expWriteData = lineWdata[idx];
      mask         = lineMask[idx][1:0];
      checkEn      = 1'b1;
   endtask

   initial begin
      reset        = 1'b1;
      instrReady   = 1'b0;
      instr        = '0;
      readData     = '0;
      checkEn      = 1'b0;
      testNum      = 0;
      expPc        = '0;
      expStrobe    = 1'b0;
      expWrite     = 1'b0;
      expAluResult = '0;
      expWriteData = '0;
      mask         = '0;
      void'($urandom(32'h702f));
      loadTrace(loadOk);
      traceLoaded  = loadOk;
      if (!loadOk) begin
         $display("TESTBENCH FAILED");
         $finish;
      end else begin
         repeat (RESET_CYCLES) @(posedge clk);
         @(negedge clk);
         reset = 1'b0;
         for (int i = 0; i < lineTest.size(); i++) begin
            driveLine(i);
            @(negedge clk);
         end
         checkEn    = 1'b0;
         instrReady = 1'b0;
         u_checker.finishReport();
         if (errorCount == 0 && u_armCore.u_armCoreAssert.failCount == 0) begin
            $display("TESTBENCH PASSED");
         end else begin
            $display("TESTBENCH FAILED");
         end
         $finish;
      end
   end

   // Watchdog sized from the trace length
   initial begin
      wait (traceLoaded);
      #((lineTest.size() + WATCHDOG_SLACK) * CLK_PERIOD);
      $display("Timeout: the trace replay did not finish in the expected time");
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

/* armCore_assert.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Handshake assertions bound into every armCore instance
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module armCoreAssert import armPkg::*; (
   input logic  clk,
   input logic  reset,
   input logic  instrReady,
   input word_t pc,
   input logic  memStrobe,
   input logic  memWrite
);

   int failCount = 0;   // Failed assertion count

   // A store is always a strobed access
   assert property (@(posedge clk) disable iff (reset) memWrite |-> memStrobe)
      else begin
         failCount++;
         $error("memWrite high without memStrobe");
      end

   assert property (@(posedge clk) disable iff (reset) !instrReady |-> !memStrobe)
      else begin
         failCount++;
         $error("memStrobe high while instrReady is low");
      end

   // Stalled edge leaves the PC where it was
   assert property (@(posedge clk) disable iff (reset) !instrReady |=> $stable(pc))
      else begin
         failCount++;
         $error("pc changed across a stalled cycle");
      end

endmodule

bind armCore armCoreAssert u_armCoreAssert (.*);

/* armDatapath.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PC, immediate extension, operand muxes, register file and ALU
// PC only advances while instrReady is high
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module armDatapath import armPkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  word_t      instr,
   input  word_t      readData,
   input  logic       instrReady,
   input  logic       regWrite,
   input  logic       pcSrc,
   input  logic [1:0] regSrc,
   input  immSrc_t    immSrc,
   input  logic       aluSrc,
   input  logic       memToReg,
   input  aluCtrl_t   aluCtrl,
   output word_t      pc,
   output word_t      aluResult,
   output word_t      writeData,
   output flags_t     aluFlags
);

   word_t    pcNext, pcPlus4, pcPlus8;
   word_t    extImm, srcA, srcB, result;
   regAddr_t ra1, ra2;

   assign pcPlus4 = pc + PC_STEP;
   assign pcPlus8 = pcPlus4 + PC_READ_OFFSET;
   assign pcNext  = pcSrc ? result : pcPlus4;   // Branch target comes through the ALU

   always_ff @(posedge clk, posedge reset) begin
      if (reset)
         pc <= RESET_PC;
      else if (instrReady)
         pc <= pcNext;
   end

   always_comb begin
      case (immSrc)
         IMM_DP8:      extImm = {24'd0, instr[7:0]};
         IMM_MEM12:    extImm = {20'd0, instr[11:0]};
         IMM_BRANCH24: extImm = {{6{instr[23]}}, instr[23:0], 2'b00};   // Word offset
         default:      extImm = '0;
      endcase
   end

   assign ra1 = regSrc[0] ? PC_REG : instr[19:16];
   assign ra2 = regSrc[1] ? instr[15:12] : instr[3:0];   // Rd for STR data

   armRegFile u_regFile (
      .clk (clk),
      .we  (regWrite),
      .ra1 (ra1),
      .ra2 (ra2),
      .wa  (instr[15:12]),
      .wd  (result),
      .r15 (pcPlus8),
      .rd1 (srcA),
      .rd2 (writeData)
   );

   assign srcB = aluSrc ? extImm : writeData;

   armAlu u_alu (
      .a        (srcA),
      .b        (srcB),
      .aluCtrl  (aluCtrl),
      .result   (aluResult),
      .aluFlags (aluFlags)
   );

   assign result = memToReg ? readData : aluResult;

endmodule

/* armDecoder.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Main and ALU decoders, instruction fields to unconditional controls
// The condition unit later qualifies the write intents
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module armDecoder import armPkg::*; (
   input  word_t      instr,
   output logic       regW,
   output logic       memW,
   output logic       branch,
   output logic       noWrite,
   output logic [1:0] flagW,
   output logic [1:0] regSrc,
   output immSrc_t    immSrc,
   output logic       aluSrc,
   output logic       memToReg,
   output aluCtrl_t   aluCtrl
);

   logic [1:0] op;
   logic       immBit;
   logic [3:0] funct;
   logic       sBit;     // S bit, or L bit on memory ops
   logic       aluOp;

   assign op     = instr[27:26];
   assign immBit = instr[25];
   assign funct  = instr[24:21];
   assign sBit   = instr[20];

   // Main decoder
   always_comb begin
      regSrc   = 2'b00;
      immSrc   = IMM_DP8;
      aluSrc   = 1'b0;
      memToReg = 1'b0;
      regW     = 1'b0;
      memW     = 1'b0;
      branch   = 1'b0;
      aluOp    = 1'b0;
      case (op)
         OP_DATA: begin
            aluSrc = immBit;   // imm8 or Rm
            regW   = 1'b1;
            aluOp  = 1'b1;
         end
         OP_MEM: begin
            immSrc = IMM_MEM12;
            aluSrc = 1'b1;
            if (sBit) begin    // LDR
               memToReg = 1'b1;
               regW     = 1'b1;
            end else begin     // STR, Rd goes out on port 2
               regSrc = 2'b10;
               memW   = 1'b1;
            end
         end
         OP_BRANCH: begin
            regSrc = 2'b01;    // Base is R15
            immSrc = IMM_BRANCH24;
            aluSrc = 1'b1;
            branch = 1'b1;
         end
         default: regW = 1'b0;
      endcase
   end

   // ALU decoder
   always_comb begin
      aluCtrl = ALU_ADD;       // Address and branch target sum
      noWrite = 1'b0;
      flagW   = 2'b00;
      if (aluOp) begin
         case (funct)
            FUNCT_ADD: aluCtrl = ALU_ADD;
            FUNCT_SUB: aluCtrl = ALU_SUB;
            FUNCT_AND: aluCtrl = ALU_AND;
            FUNCT_ORR: aluCtrl = ALU_ORR;
            FUNCT_EOR: aluCtrl = ALU_EOR;
            FUNCT_CMP: begin
               aluCtrl = ALU_SUB;
               noWrite = 1'b1;
            end
            FUNCT_TST: begin
               aluCtrl = ALU_AND;
               noWrite = 1'b1;
            end
            default: noWrite = 1'b1;   // Unsupported opcode leaves Rd alone
         endcase
         flagW[1] = sBit;              // NZ on any S
         flagW[0] = sBit & ((funct == FUNCT_ADD) || (funct == FUNCT_SUB) ||
                            (funct == FUNCT_CMP));
      end
   end

endmodule

/* armPkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths, types and instruction encodings shared by the ARMv4 core
// Each core module imports what it needs with armPkg::*
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package armPkg;

   typedef logic [31:0] word_t;     // Data, address and PC
   typedef logic [3:0]  regAddr_t;
   typedef logic [3:0]  cond_t;
   typedef logic [3:0]  flags_t;    // N Z C V
   typedef logic [2:0]  aluCtrl_t;
   typedef logic [1:0]  immSrc_t;

   localparam word_t    RESET_PC       = 32'h0000_0000;
   localparam word_t    PC_STEP        = 32'd4;
   localparam word_t    PC_READ_OFFSET = 32'd4;   // Second step so R15 reads PC + 8
   localparam regAddr_t PC_REG         = 4'd15;

   // Op class in instr[27:26]
   localparam logic [1:0] OP_DATA   = 2'b00;
   localparam logic [1:0] OP_MEM    = 2'b01;
   localparam logic [1:0] OP_BRANCH = 2'b10;

   // Data-processing opcode in instr[24:21]
   localparam logic [3:0] FUNCT_AND = 4'b0000;
   localparam logic [3:0] FUNCT_EOR = 4'b0001;
   localparam logic [3:0] FUNCT_SUB = 4'b0010;
   localparam logic [3:0] FUNCT_ADD = 4'b0100;
   localparam logic [3:0] FUNCT_TST = 4'b1000;
   localparam logic [3:0] FUNCT_CMP = 4'b1010;
   localparam logic [3:0] FUNCT_ORR = 4'b1100;

   localparam aluCtrl_t ALU_ADD = 3'b000;
   localparam aluCtrl_t ALU_SUB = 3'b001;
   localparam aluCtrl_t ALU_AND = 3'b010;
   localparam aluCtrl_t ALU_ORR = 3'b011;
   localparam aluCtrl_t ALU_EOR = 3'b100;

   localparam immSrc_t IMM_DP8      = 2'b00;
   localparam immSrc_t IMM_MEM12    = 2'b01;
   localparam immSrc_t IMM_BRANCH24 = 2'b10;

   localparam cond_t COND_EQ = 4'b0000;
   localparam cond_t COND_NE = 4'b0001;
   localparam cond_t COND_CS = 4'b0010;
   localparam cond_t COND_CC = 4'b0011;
   localparam cond_t COND_MI = 4'b0100;
   localparam cond_t COND_PL = 4'b0101;
   localparam cond_t COND_VS = 4'b0110;
   localparam cond_t COND_VC = 4'b0111;
   localparam cond_t COND_HI = 4'b1000;
   localparam cond_t COND_LS = 4'b1001;
   localparam cond_t COND_GE = 4'b1010;
   localparam cond_t COND_LT = 4'b1011;
   localparam cond_t COND_GT = 4'b1100;
   localparam cond_t COND_LE = 4'b1101;
   localparam cond_t COND_AL = 4'b1110;

endpackage

/* armRegFile.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file, two async reads and one clocked write, R15 from PC
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module armRegFile import armPkg::*; (
   input  logic     clk,
   input  logic     we,
   input  regAddr_t ra1,
   input  regAddr_t ra2,
   input  regAddr_t wa,
   input  word_t    wd,
   input  word_t    r15,
   output word_t    rd1,
   output word_t    rd2
);

   word_t regs [0:14];   // R0 to R14 only

   // A write aimed at R15 has nowhere to land
   always_ff @(posedge clk) begin
      if (we && (wa != PC_REG))
         regs[wa] <= wd;
   end

   assign rd1 = (ra1 == PC_REG) ? r15 : regs[ra1];
   assign rd2 = (ra2 == PC_REG) ? r15 : regs[ra2];

endmodule

/* armTrace.txt */
# test ready instr readData expPc memStrobe memWrite aluResult writeData mask (test decimal, rest hex)
# mask bit 0 compares aluResult, bit 1 compares writeData; instr on ready 0 lines is replaced
1 1 E20F0000 00000000 00000000 0 0 00000000 00000000 1
1 1 E2801007 00000000 00000004 0 0 00000007 00000000 1
1 1 02801055 00000000 00000008 0 0 00000055 00000000 1
1 1 12812001 00000000 0000000C 0 0 00000008 00000000 1
1 1 E1813002 00000000 00000010 0 0 0000000F 00000000 1
2 1 E2814010 00000000 00000014 0 0 00000017 00000000 1
2 1 E0445001 00000000 00000018 0 0 00000010 00000000 1
2 1 E204600F 00000000 0000001C 0 0 00000007 00000000 1
2 1 E3857003 00000000 00000020 0 0 00000013 00000000 1
2 1 E0278004 00000000 00000024 0 0 00000004 00000000 1
2 1 E0889007 00000000 00000028 0 0 00000017 00000000 1
3 1 E1513001 00000000 0000002C 0 0 00000000 00000000 1
3 1 02800001 00000000 00000030 0 0 00000001 00000000 1
3 1 12800001 00000000 00000034 0 0 00000002 00000000 1
3 1 22800001 00000000 00000038 0 0 00000002 00000000 1
3 1 32800001 00000000 0000003C 0 0 00000003 00000000 1
3 1 82800001 00000000 00000040 0 0 00000003 00000000 1
3 1 92800001 00000000 00000044 0 0 00000003 00000000 1
3 1 E1513002 00000000 00000048 0 0 FFFFFFFF 00000000 1
3 1 42800001 00000000 0000004C 0 0 00000004 00000000 1
3 1 52800001 00000000 00000050 0 0 00000005 00000000 1
3 1 A2800001 00000000 00000054 0 0 00000005 00000000 1
3 1 B2800001 00000000 00000058 0 0 00000005 00000000 1
3 1 D2800001 00000000 0000005C 0 0 00000006 00000000 1
3 1 E3145008 00000000 00000060 0 0 00000000 00000000 1
3 1 E282A001 00000000 00000064 0 0 00000009 00000000 1
3 1 02800001 00000000 00000068 0 0 00000007 00000000 1
3 1 E1525001 00000000 0000006C 0 0 00000001 00000000 1
3 1 C2800001 00000000 00000070 0 0 00000008 00000000 1
3 1 E183B005 00000000 00000074 0 0 0000001F 00000000 1
3 1 E280B000 00000000 00000078 0 0 00000008 00000000 1
4 1 E5884020 00000000 0000007C 1 1 00000024 00000017 3
4 1 E598C010 12345678 00000080 1 0 00000014 00000000 1
4 1 E28CD001 00000000 00000084 0 0 12345679 00000000 1
4 1 05884020 00000000 00000088 0 0 00000024 00000017 3
5 1 E28FE000 00000000 0000008C 0 0 00000094 00000000 1
5 1 EA000002 00000000 00000090 0 0 000000A0 00000000 1
5 1 0A00000F 00000000 000000A0 0 0 000000E4 00000000 1
5 1 EAFFFFFB 00000000 000000A4 0 0 00000098 00000000 1
5 1 E24FC004 00000000 00000098 0 0 0000009C 00000000 1
6 0 00000000 00000000 0000009C 0 0 00000000 00000000 0
6 0 00000000 00000000 0000009C 0 0 00000000 00000000 0
6 1 E588D030 00000000 0000009C 1 1 00000034 12345679 3
6 0 00000000 00000000 000000A0 0 0 00000000 00000000 0
6 1 E0512001 00000000 000000A0 0 0 00000000 00000000 1
6 0 00000000 00000000 000000A4 0 0 00000000 00000000 0
6 1 02800001 00000000 000000A4 0 0 00000009 00000000 1
6 1 E0803002 00000000 000000A8 0 0 00000009 00000000 1

/* verilog.f */
armPkg.sv
armAlu.sv
armRegFile.sv
armDecoder.sv
armCondUnit.sv
armDatapath.sv
armCore.sv
armCore_assert.sv
armCoreChecker.sv
armCoreTb.sv
